//--- verilog.f
+incdir+include
hw/agcPkg.sv
hw/hostBusBridge.sv
hw/log2Converter.sv
hw/agcLoopFilter.sv
hw/pcmAgcLoop.sv
hw/agcSubsystem.sv
tb/agcSubsystem_properties.sv
tb/agcSubsystemTb.sv

//--- run.sh
#!/bin/sh
# build and run the AGC subsystem testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module agcSubsystemTb -f verilog.f -o agcSim

# keep running past assertion errors so the testbench prints its verdict.
./obj_dir/agcSim +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log

if grep -q "=== FAIL ===" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"

//--- tb/agcSubsystemTb.sv
//////////////////////////////
// AGC subsystem testbench
//////////////////////////////
`timescale 1ns/1ns
`default_nettype none

`include "agcAddressMap.svh"

module agcSubsystemTb
    import agcPkg::*;
();

    localparam logic [SPACE_WIDTH-1:0]         LOOP_SPACE = 11'h040;
    localparam logic signed [SAMPLE_WIDTH-1:0] MOST_NEGATIVE = 18'sh20000;
    localparam int                             TIMEOUT = 50;
    localparam logic [31:0]                    SEED = 32'h6fca81ed;

    logic                           clk;
    logic                           reset;
    logic                           req;
    logic                           write;
    logic [3:0]                     byteEn;
    logic [ADDR_WIDTH-1:0]          addr;
    logic [DATA_WIDTH-1:0]          wdata;
    logic                           ack;
    logic [DATA_WIDTH-1:0]          rdata;
    logic signed [SAMPLE_WIDTH-1:0] rx;
    logic                           clkEn;
    logic [GAIN_WIDTH-1:0]          agcGain;

    // samples of the current run, and the model state.
    logic signed [SAMPLE_WIDTH-1:0] samples[$];
    logic [DATA_WIDTH-1:0]          regModel[3];
    logic [DATA_WIDTH-1:0]          intModel;
    int                             errors;
    int                             testsRun;
    int                             testsFailed;

    agcSubsystem DUT (
        .clk     (clk),
        .reset   (reset),
        .req     (req),
        .write   (write),
        .byteEn  (byteEn),
        .addr    (addr),
        .wdata   (wdata),
        .ack     (ack),
        .rdata   (rdata),
        .rx      (rx),
        .clkEn   (clkEn),
        .agcGain (agcGain)
    );

    bind agcSubsystem agcSubsystem_properties #(
        .RegSpace (RegSpace)
    ) props (
        .clk     (clk),
        .reset   (reset),
        .req     (req),
        .ack     (ack),
        .wr0     (wr0),
        .wr1     (wr1),
        .wr2     (wr2),
        .wr3     (wr3),
        .busAddr (busAddr),
        .busDin  (busDin),
        .agcGain (agcGain)
    );

    // 4 ns clock.
    always #2 clk = ~clk;

    function automatic logic [ADDR_WIDTH-1:0] regAddr(input logic [1:0] idx);
        return {LOOP_SPACE, idx};
    endfunction

    // implemented bits per register layout.
    function automatic logic [DATA_WIDTH-1:0] regMask(input logic [1:0] idx);
        case (idx)
            `AGC_REG_CONTROL:   return 32'h0000_00F3;
            `AGC_REG_REFERENCE: return 32'h0000_00FF;
            `AGC_REG_MANUAL:    return 32'h001F_FFFF;
            default:            return 32'h0;
        endcase
    endfunction

    function automatic logic [DATA_WIDTH-1:0] mergeBytes(
        input logic [DATA_WIDTH-1:0] old,
        input logic [DATA_WIDTH-1:0] data,
        input logic [3:0]            be
    );
        logic [DATA_WIDTH-1:0] mask;
        for (int b = 0; b < 4; b++) begin
            mask[8*b +: 8] = {8{be[b]}};
        end
        return (old & ~mask) | (data & mask);
    endfunction

    // magnitude bits 16:1 with the most negative code clamped to 131071.
    function automatic logic [LEVEL_WIDTH-1:0] levelOf(input logic signed [SAMPLE_WIDTH-1:0] s);
        int mag;
        if (s == MOST_NEGATIVE) begin
            mag = 131071;
        end else if (s < 0) begin
            mag = -int'(s);
        end else begin
            mag = int'(s);
        end
        return mag[16:1];
    endfunction

    function automatic logic [LOG_WIDTH-1:0] logOf(input logic [LEVEL_WIDTH-1:0] level);
        int p;
        int scaled;
        if (level == 0) begin
            return '0;
        end
        // floor of log2.
        p = $clog2(int'(level) + 1) - 1;
        // the four bits under the leading one with zero padding.
        scaled = (int'(level) << 4) >> p;
        return {4'(p), 4'(scaled)};
    endfunction

    // integrate every queued sample with clamping to 32 bits.
    function automatic logic [DATA_WIDTH-1:0] modelRun(
        input logic [DATA_WIDTH-1:0] start,
        input logic [7:0]            target,
        input int                    shift
    );
        longint acc;
        acc = longint'(start);
        foreach (samples[i]) begin
            acc = acc + ((longint'(target) - longint'(logOf(levelOf(samples[i])))) <<< shift);
            if (acc < 0) begin
                acc = 0;
            end else if (acc > 64'sh0_FFFF_FFFF) begin
                acc = 64'sh0_FFFF_FFFF;
            end
        end
        return acc[31:0];
    endfunction

    task automatic checkValue(
        input string                 name,
        input logic [DATA_WIDTH-1:0] expected,
        input logic [DATA_WIDTH-1:0] actual
    );
        assert (actual === expected) else begin
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic finishTest(input string name, input int mark);
        testsRun++;
        if (errors == mark) begin
            $display("%s: ok", name);
        end else begin
            testsFailed++;
            $display("%s: %0d errors", name, errors - mark);
        end
    endtask

    // wait for ack, take rdata, drop req and wait for ack to fall.
    task automatic completeHandshake(output logic [DATA_WIDTH-1:0] readData);
        int cycles;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
        end while (!ack && cycles < TIMEOUT);
        if (!ack) begin
            $display("host access to %h got no ack within %0d cycles", addr, TIMEOUT);
            errors++;
        end
        readData = rdata;
        req <= 1'b0;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
        end while (ack && cycles < TIMEOUT);
        if (ack) begin
            $display("ack stayed high %0d cycles after req was dropped", TIMEOUT);
            errors++;
        end
    endtask

    task automatic hostWrite(
        input logic [ADDR_WIDTH-1:0] a,
        input logic [DATA_WIDTH-1:0] data,
        input logic [3:0]            be
    );
        logic [DATA_WIDTH-1:0] unused;
        @(posedge clk);
        addr   <= a;
        wdata  <= data;
        byteEn <= be;
        write  <= 1'b1;
        req    <= 1'b1;
        completeHandshake(unused);
    endtask

    task automatic hostRead(input logic [ADDR_WIDTH-1:0] a, output logic [DATA_WIDTH-1:0] data);
        @(posedge clk);
        addr   <= a;
        byteEn <= 4'h0;
        write  <= 1'b0;
        req    <= 1'b1;
        completeHandshake(data);
    endtask

    // every queued sample on consecutive cycles.
    task automatic driveSamples();
        foreach (samples[i]) begin
            @(posedge clk);
            rx    <= samples[i];
            clkEn <= 1'b1;
        end
        @(posedge clk);
        clkEn <= 1'b0;
        // integrator settles four edges after the last sample.
        repeat (6) @(posedge clk);
    endtask

    // one tracking run over the queue checked against the model.
    task automatic trackRun(
        input string                  name,
        input logic [7:0]             target,
        input logic [3:0]             shift,
        output logic [DATA_WIDTH-1:0] result
    );
        hostWrite(regAddr(`AGC_REG_REFERENCE), 32'(target), 4'hF);
        hostWrite(regAddr(`AGC_REG_CONTROL), {24'h0, shift, 2'b00, MODE_TRACK}, 4'hF);
        driveSamples();
        intModel = modelRun(intModel, target, int'(shift));
        hostRead(regAddr(`AGC_REG_INTEGRATOR), result);
        checkValue(name, intModel, result);
    endtask

    initial begin
        logic [DATA_WIDTH-1:0]          data;
        logic [DATA_WIDTH-1:0]          got;
        logic [3:0]                     be;
        logic [GAIN_WIDTH-1:0]          gain;
        logic signed [SAMPLE_WIDTH-1:0] base;
        logic signed [SAMPLE_WIDTH-1:0] logInputs[5];
        int                             mark;

        void'($urandom(SEED));
        clk         = 1'b0;
        reset       = 1'b1;
        req         = 1'b0;
        write       = 1'b0;
        byteEn      = 4'h0;
        addr        = '0;
        wdata       = '0;
        rx          = '0;
        clkEn       = 1'b0;
        errors      = 0;
        testsRun    = 0;
        testsFailed = 0;
        intModel    = 32'h8000_0000;
        foreach (regModel[i]) begin
            regModel[i] = '0;
        end
        repeat (4) @(posedge clk);
        reset <= 1'b0;

        // hold mode keeps the gain at the top of the mid scale integrator.
        mark = errors;
        repeat (40) begin
            @(posedge clk);
            rx    <= SAMPLE_WIDTH'($urandom());
            clkEn <= 1'($urandom());
        end
        @(posedge clk);
        clkEn <= 1'b0;
        checkValue("hold gain", 32'h0010_0000, 32'(agcGain));
        finishTest("hold mode", mark);

        // full and partial byte writes with readback.
        mark = errors;
        for (int r = 0; r < 3; r++) begin
            for (int k = 0; k < 2; k++) begin
                data = $urandom();
                // the second write always leaves at least one lane untouched.
                be   = (k == 0) ? 4'hF : 4'($urandom_range(14, 1));
                hostWrite(regAddr(2'(r)), data, be);
                regModel[r] = mergeBytes(regModel[r], data, be) & regMask(2'(r));
                hostRead(regAddr(2'(r)), got);
                checkValue($sformatf("register %0d write %0d", r, k), regModel[r], got);
            end
        end
        hostRead({LOOP_SPACE + 11'd1, `AGC_REG_REFERENCE}, got);
        checkValue("read outside space", 32'h0, got);
        hostWrite(regAddr(`AGC_REG_CONTROL), 32'(MODE_HOLD), 4'hF);
        finishTest("register access", mark);

        // manual gain drives the output directly.
        mark = errors;
        gain = GAIN_WIDTH'($urandom());
        hostWrite(regAddr(`AGC_REG_MANUAL), 32'(gain), 4'hF);
        hostWrite(regAddr(`AGC_REG_CONTROL), 32'(MODE_MANUAL), 4'hF);
        @(posedge clk);
        checkValue("manual gain", 32'(gain), 32'(agcGain));
        hostWrite(regAddr(`AGC_REG_CONTROL), 32'(MODE_HOLD), 4'hF);
        finishTest("manual mode", mark);

        // single samples through the log converter.
        mark = errors;
        base = SAMPLE_WIDTH'($urandom());
        logInputs = '{base, -base, 18'sd0, MOST_NEGATIVE, SAMPLE_WIDTH'($urandom())};
        data = 32'(8'($urandom()));
        for (int i = 0; i < 5; i++) begin
            samples.delete();
            samples.push_back(logInputs[i]);
            trackRun($sformatf("log sample %0d", i), data[7:0], 4'd0, got);
        end
        finishTest("log conversion", mark);

        // consecutive enables keep two samples in the log pipeline.
        mark = errors;
        samples.delete();
        repeat (24) samples.push_back(SAMPLE_WIDTH'($urandom()));
        trackRun("back to back", 8'($urandom()), 4'd2, got);
        finishTest("back-to-back samples", mark);

        // constant high level pulls the integrator down to the floor.
        mark = errors;
        samples.delete();
        repeat (200) samples.push_back(18'sh1F000);
        trackRun("converge shift 4", 8'h20, 4'd4, got);
        repeat (200) samples.push_back(18'sh1F000);
        trackRun("saturate low", 8'h20, 4'd15, got);
        checkValue("saturate low floor", 32'h0, got);
        // zero level below the reference drives it to the ceiling.
        samples.delete();
        repeat (600) samples.push_back(18'sd0);
        trackRun("saturate high", 8'hFF, 4'd15, got);
        checkValue("saturate high ceiling", 32'hFFFF_FFFF, got);
        finishTest("loop convergence", mark);

        $display("tests %0d, failed %0d, check errors %0d, assertion failures %0d",
                 testsRun, testsFailed, errors, DUT.props.failures);
        if (errors == 0 && DUT.props.failures == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb/agcSubsystem_properties.sv
//////////////////////////////
// AGC subsystem assertions
//////////////////////////////
`timescale 1ns/1ns
`default_nettype none

`include "agcAddressMap.svh"

module agcSubsystem_properties
    import agcPkg::*;
#(
    parameter logic [SPACE_WIDTH-1:0] RegSpace = 11'h040
) (
    input wire logic                  clk,
    input wire logic                  reset,
    input wire logic                  req,
    input wire logic                  ack,
    input wire logic                  wr0,
    input wire logic                  wr1,
    input wire logic                  wr2,
    input wire logic                  wr3,
    input wire logic [ADDR_WIDTH-1:0] busAddr,
    input wire logic [DATA_WIDTH-1:0] busDin,
    input wire logic [GAIN_WIDTH-1:0] agcGain
);

    // count of failed assertions for the closing summary.
    int   failures = 0;
    logic anyStrobe;
    logic holdMode;

    assign anyStrobe = wr0 | wr1 | wr2 | wr3;

    // shadow of the CONTROL mode field from byte lane 0.
    always_ff @(posedge clk) begin
        if (reset) begin
            holdMode <= 1'b1;
        end else if (wr0 && busAddr == {RegSpace, `AGC_REG_CONTROL}) begin
            holdMode <= (busDin[1:0] == MODE_HOLD);
        end
    end

    // bridge comes out of reset idle.
    ackAfterReset: assert property (@(posedge clk) reset |=> !ack)
        else begin
            failures++;
            $error("ack high in the cycle after reset");
        end

    // ack only answers a pending request.
    ackNeedsReq: assert property (@(posedge clk) disable iff (reset) $rose(ack) |-> req)
        else begin
            failures++;
            $error("ack rose without req");
        end

    // ack is held until the host lets go of req.
    ackHolds: assert property (@(posedge clk) disable iff (reset) ack && req |=> ack)
        else begin
            failures++;
            $error("ack dropped while req still high");
        end

    // one strobe cycle followed by ack with the strobes quiet.
    strobeOnce: assert property (@(posedge clk) disable iff (reset)
        anyStrobe |=> ack && !anyStrobe)
        else begin
            failures++;
            $error("strobe not a single pulse followed by ack");
        end

    // no second pulse while the request is acknowledged.
    strobeQuietAcked: assert property (@(posedge clk) disable iff (reset) ack |-> !anyStrobe)
        else begin
            failures++;
            $error("strobe during acked phase");
        end

    // hold mode freezes the gain until a register write.
    holdStable: assert property (@(posedge clk) disable iff (reset)
        holdMode && !anyStrobe |=> $stable(agcGain))
        else begin
            failures++;
            $error("agcGain moved in hold mode");
        end

endmodule

`default_nettype wire

//--- hw/agcSubsystem.sv
//////////////////////////////
// AGC subsystem top
//////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module agcSubsystem
    import agcPkg::*;
#(
    parameter logic [SPACE_WIDTH-1:0] RegSpace = 11'h040
) (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           req,
    input  logic                           write,
    input  logic [3:0]                     byteEn,
    input  logic [ADDR_WIDTH-1:0]          addr,
    input  logic [DATA_WIDTH-1:0]          wdata,
    output logic                           ack,
    output logic [DATA_WIDTH-1:0]          rdata,
    input  logic signed [SAMPLE_WIDTH-1:0] rx,
    input  logic                           clkEn,
    output logic [GAIN_WIDTH-1:0]          agcGain
);

    // internal register bus.
    logic                  wr0;
    logic                  wr1;
    logic                  wr2;
    logic                  wr3;
    logic [ADDR_WIDTH-1:0] busAddr;
    logic [DATA_WIDTH-1:0] busDin;
    logic [DATA_WIDTH-1:0] busDout;

    hostBusBridge bridge (
        .clk     (clk),
        .reset   (reset),
        .req     (req),
        .write   (write),
        .byteEn  (byteEn),
        .addr    (addr),
        .wdata   (wdata),
        .ack     (ack),
        .rdata   (rdata),
        .wr0     (wr0),
        .wr1     (wr1),
        .wr2     (wr2),
        .wr3     (wr3),
        .busAddr (busAddr),
        .busDin  (busDin),
        .busDout (busDout)
    );

    pcmAgcLoop #(
        .RegSpace (RegSpace)
    ) agcLoop (
        .clk     (clk),
        .reset   (reset),
        .clkEn   (clkEn),
        .rx      (rx),
        .wr0     (wr0),
        .wr1     (wr1),
        .wr2     (wr2),
        .wr3     (wr3),
        .addr    (busAddr),
        .din     (busDin),
        .dout    (busDout),
        .agcGain (agcGain)
    );

endmodule

`default_nettype wire

//--- hw/pcmAgcLoop.sv
//////////////////////////////
// PCM AGC loop
//////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module pcmAgcLoop
    import agcPkg::*;
#(
    parameter logic [SPACE_WIDTH-1:0] RegSpace = 11'h040
) (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           clkEn,
    input  logic signed [SAMPLE_WIDTH-1:0] rx,
    input  logic                           wr0,
    input  logic                           wr1,
    input  logic                           wr2,
    input  logic                           wr3,
    input  logic [ADDR_WIDTH-1:0]          addr,
    input  logic [DATA_WIDTH-1:0]          din,
    output logic [DATA_WIDTH-1:0]          dout,
    output logic [GAIN_WIDTH-1:0]          agcGain
);

    logic [SAMPLE_WIDTH-1:0] negated;
    logic [SAMPLE_WIDTH-2:0] magnitude;
    logic [LEVEL_WIDTH-1:0]  rxLevel;
    logic                    levelValid;
    logic [LOG_WIDTH-1:0]    logLevel;
    logic                    logValid;
    logic                    cs;
    logic [DATA_WIDTH-1:0]   loopOutput;

    // rectify, the most negative code would overflow so clamp it.
    always_comb begin
        negated = -rx;
        if (rx[SAMPLE_WIDTH-1] && ~|rx[SAMPLE_WIDTH-2:0]) begin
            magnitude = '1;
        end else if (rx[SAMPLE_WIDTH-1]) begin
            magnitude = negated[SAMPLE_WIDTH-2:0];
        end else begin
            magnitude = rx[SAMPLE_WIDTH-2:0];
        end
    end

    // level is taken at the symbol enable only.
    always_ff @(posedge clk) begin
        if (clkEn) begin
            rxLevel <= magnitude[SAMPLE_WIDTH-2 -: LEVEL_WIDTH];
        end
    end

    // valid lines up with the new level.
    always_ff @(posedge clk) begin
        if (reset) begin
            levelValid <= 1'b0;
        end else begin
            levelValid <= clkEn;
        end
    end

    log2Converter levelLog (
        .clk      (clk),
        .reset    (reset),
        .syncIn   (levelValid),
        .linear   (rxLevel),
        .log      (logLevel),
        .logValid (logValid)
    );

    // upper address bits select this channel.
    assign cs = (addr[ADDR_WIDTH-1:REG_INDEX_WIDTH] == RegSpace);

    agcLoopFilter loopFilter (
        .clk         (clk),
        .reset       (reset),
        .cs          (cs),
        .wr0         (wr0),
        .wr1         (wr1),
        .wr2         (wr2),
        .wr3         (wr3),
        .addr        (addr[REG_INDEX_WIDTH-1:0]),
        .din         (din),
        .signalLevel (logLevel),
        .signalValid (logValid),
        .dout        (dout),
        .loopOutput  (loopOutput)
    );

    // amplifier gets the top of the integrator.
    assign agcGain = loopOutput[DATA_WIDTH-1 -: GAIN_WIDTH];

endmodule

`default_nettype wire

//--- hw/agcLoopFilter.sv
//////////////////////////////
// AGC loop filter
//////////////////////////////
`timescale 1ns/1ns
`default_nettype none

`include "agcAddressMap.svh"

module agcLoopFilter
    import agcPkg::*;
(
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       cs,
    input  logic                       wr0,
    input  logic                       wr1,
    input  logic                       wr2,
    input  logic                       wr3,
    input  logic [REG_INDEX_WIDTH-1:0] addr,
    input  logic [DATA_WIDTH-1:0]      din,
    input  logic [LOG_WIDTH-1:0]       signalLevel,
    input  logic                       signalValid,
    output logic [DATA_WIDTH-1:0]      dout,
    output logic [DATA_WIDTH-1:0]      loopOutput
);

    // implemented bits of each writable register.
    localparam logic [DATA_WIDTH-1:0] CONTROL_MASK   = 32'h0000_00F3;
    localparam logic [DATA_WIDTH-1:0] REFERENCE_MASK = 32'h0000_00FF;
    localparam logic [DATA_WIDTH-1:0] MANUAL_MASK    = 32'h001F_FFFF;
    // error shifted by up to 15 needs this many bits.
    localparam int STEP_WIDTH = LOG_WIDTH + 1 + 15;
    localparam int MANUAL_SHIFT = DATA_WIDTH - GAIN_WIDTH;

    logic [3:0]                   lanes;
    logic [DATA_WIDTH-1:0]        controlReg;
    logic [DATA_WIDTH-1:0]        referenceReg;
    logic [DATA_WIDTH-1:0]        manualReg;
    logic [DATA_WIDTH-1:0]        integrator;
    agcModeT                      mode;
    logic [3:0]                   gainShift;
    logic signed [LOG_WIDTH:0]    error;
    logic signed [STEP_WIDTH-1:0] step;
    logic signed [DATA_WIDTH+1:0] sum;
    logic [DATA_WIDTH-1:0]        nextIntegrator;

    // replace only the bytes whose strobe is set.
    function automatic logic [DATA_WIDTH-1:0] laneMerge(
        input logic [DATA_WIDTH-1:0] old,
        input logic [DATA_WIDTH-1:0] data,
        input logic [3:0]            strobes
    );
        logic [DATA_WIDTH-1:0] merged;
        merged = old;
        for (int b = 0; b < 4; b++) begin
            if (strobes[b]) begin
                merged[8*b +: 8] = data[8*b +: 8];
            end
        end
        return merged;
    endfunction

    assign lanes = {wr3, wr2, wr1, wr0};

    // control fields.
    assign mode      = agcModeT'(controlReg[1:0]);
    assign gainShift = controlReg[7:4];

    // error is reference minus measured level, both unsigned logs.
    always_comb begin
        error = $signed({1'b0, referenceReg[LOG_WIDTH-1:0]}) - $signed({1'b0, signalLevel});
        step  = error;
        step  = step <<< gainShift;
        sum   = $signed({2'b00, integrator}) + step;
        // clamp to the unsigned 32-bit range.
        if (sum[DATA_WIDTH+1]) begin
            nextIntegrator = '0;
        end else if (sum[DATA_WIDTH]) begin
            nextIntegrator = '1;
        end else begin
            nextIntegrator = sum[DATA_WIDTH-1:0];
        end
    end

    // register writes and the integrator.
    always_ff @(posedge clk) begin
        if (reset) begin
            controlReg   <= '0;
            referenceReg <= '0;
            manualReg    <= '0;
            // mid scale gain out of reset.
            integrator   <= 32'h8000_0000;
        end else begin
            if (cs && addr == `AGC_REG_CONTROL) begin
                controlReg <= laneMerge(controlReg, din, lanes) & CONTROL_MASK;
            end
            if (cs && addr == `AGC_REG_REFERENCE) begin
                referenceReg <= laneMerge(referenceReg, din, lanes) & REFERENCE_MASK;
            end
            if (cs && addr == `AGC_REG_MANUAL) begin
                manualReg <= laneMerge(manualReg, din, lanes) & MANUAL_MASK;
            end
            // only tracking mode integrates.
            if (mode == MODE_TRACK && signalValid) begin
                integrator <= nextIntegrator;
            end
        end
    end

    // read mux, zero when the loop is not addressed.
    always_comb begin
        dout = '0;
        if (cs) begin
            case (addr)
                `AGC_REG_CONTROL:    dout = controlReg;
                `AGC_REG_REFERENCE:  dout = referenceReg;
                `AGC_REG_MANUAL:     dout = manualReg;
                `AGC_REG_INTEGRATOR: dout = integrator;
                default:             dout = '0;
            endcase
        end
    end

    // manual gain lands in the same bits as the integrator top.
    assign loopOutput = (mode == MODE_MANUAL)
                      ? {manualReg[GAIN_WIDTH-1:0], {MANUAL_SHIFT{1'b0}}}
                      : integrator;

endmodule

`default_nettype wire

//--- hw/log2Converter.sv
//////////////////////////////
// Linear to log2 converter
//////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module log2Converter
    import agcPkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   syncIn,
    input  logic [LEVEL_WIDTH-1:0] linear,
    output logic [LOG_WIDTH-1:0]   log,
    output logic                   logValid
);

    // each log nibble is half the output word.
    localparam int NIBBLE = LOG_WIDTH / 2;

    logic [NIBBLE-1:0]      stagePos;
    logic [LEVEL_WIDTH-1:0] stageLinear;
    logic                   stageValid;
    logic [LEVEL_WIDTH-1:0] normalized;

    // position of the highest set bit, zero for a zero input.
    function automatic logic [NIBBLE-1:0] leadingOne(input logic [LEVEL_WIDTH-1:0] value);
        logic [NIBBLE-1:0] pos;
        pos = '0;
        for (int i = 0; i < LEVEL_WIDTH; i++) begin
            if (value[i]) begin
                pos = NIBBLE'(i);
            end
        end
        return pos;
    endfunction

    // stage one, find the leading one and keep the input beside it.
    always_ff @(posedge clk) begin
        stagePos    <= leadingOne(linear);
        stageLinear <= linear;
    end

    // move the leading one to the top bit.
    // bits under it then sit just below, zero filled for small values.
    assign normalized = stageLinear << (NIBBLE'(LEVEL_WIDTH - 1) - stagePos);

    // stage two, pack position and mantissa.
    always_ff @(posedge clk) begin
        log <= {stagePos, normalized[LEVEL_WIDTH-2 -: NIBBLE]};
    end

    // valid follows the data through both stages.
    always_ff @(posedge clk) begin
        if (reset) begin
            stageValid <= 1'b0;
            logValid   <= 1'b0;
        end else begin
            stageValid <= syncIn;
            logValid   <= stageValid;
        end
    end

endmodule

`default_nettype wire

//--- hw/hostBusBridge.sv
//////////////////////////////
// Host req/ack bridge
//////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module hostBusBridge
    import agcPkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  req,
    input  logic                  write,
    input  logic [3:0]            byteEn,
    input  logic [ADDR_WIDTH-1:0] addr,
    input  logic [DATA_WIDTH-1:0] wdata,
    output logic                  ack,
    output logic [DATA_WIDTH-1:0] rdata,
    output logic                  wr0,
    output logic                  wr1,
    output logic                  wr2,
    output logic                  wr3,
    output logic [ADDR_WIDTH-1:0] busAddr,
    output logic [DATA_WIDTH-1:0] busDin,
    input  logic [DATA_WIDTH-1:0] busDout
);

    bridgeStateT state;
    logic [3:0]  strobe;
    logic        isWrite;

    // handshake FSM, strobes are high only during BRIDGE_ACCESS.
    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= BRIDGE_IDLE;
            strobe <= 4'b0000;
        end else begin
            // default drops the strobes after their single cycle.
            strobe <= 4'b0000;
            case (state)
                BRIDGE_IDLE: begin
                    if (req) begin
                        state  <= BRIDGE_ACCESS;
                        strobe <= write ? byteEn : 4'b0000;
                    end
                end
                BRIDGE_ACCESS: begin
                    state <= BRIDGE_ACKED;
                end
                BRIDGE_ACKED: begin
                    // a slow host just parks us here.
                    if (!req) begin
                        state <= BRIDGE_IDLE;
                    end
                end
                default: begin
                    state <= BRIDGE_IDLE;
                end
            endcase
        end
    end

    // latch the access when it is accepted.
    always_ff @(posedge clk) begin
        if (state == BRIDGE_IDLE && req) begin
            busAddr <= addr;
            busDin  <= wdata;
            isWrite <= write;
        end
        // read data is sampled at the end of the access cycle.
        if (state == BRIDGE_ACCESS && !isWrite) begin
            rdata <= busDout;
        end
    end

    // ack is high for the whole acked phase.
    assign ack = (state == BRIDGE_ACKED);

    assign wr0 = strobe[0];
    assign wr1 = strobe[1];
    assign wr2 = strobe[2];
    assign wr3 = strobe[3];

endmodule

`default_nettype wire

//--- hw/agcPkg.sv
//////////////////////////////
// AGC shared definitions
//////////////////////////////
`default_nettype none

package agcPkg;

    // signed soft decision from the bit synchronizer.
    localparam int SAMPLE_WIDTH = 18;
    // rectified level, magnitude bits 16:1.
    localparam int LEVEL_WIDTH = 16;
    // log2 value, leading-one position over a 4-bit mantissa.
    localparam int LOG_WIDTH = 8;
    // gain word for the external amplifier.
    localparam int GAIN_WIDTH = 21;

    // host address and register data.
    localparam int ADDR_WIDTH = 13;
    localparam int DATA_WIDTH = 32;
    // low address bits pick the register, the rest pick the loop.
    localparam int REG_INDEX_WIDTH = 2;
    localparam int SPACE_WIDTH = ADDR_WIDTH - REG_INDEX_WIDTH;

    // loop mode, held in CONTROL bits 1:0.
    typedef enum logic [1:0] {
        MODE_HOLD   = 2'd0,
        MODE_TRACK  = 2'd1,
        MODE_MANUAL = 2'd2
    } agcModeT;

    // host bridge handshake states.
    typedef enum logic [1:0] {
        BRIDGE_IDLE   = 2'd0,
        BRIDGE_ACCESS = 2'd1,
        BRIDGE_ACKED  = 2'd2
    } bridgeStateT;

endpackage

`default_nettype wire

//--- include/agcAddressMap.svh
//////////////////////////////
// AGC register indices
//////////////////////////////
`ifndef AGC_ADDRESS_MAP_SVH
`define AGC_ADDRESS_MAP_SVH

// register index is the low two address bits within the loop space.

// mode in bits 1:0, gain shift in bits 7:4.
`define AGC_REG_CONTROL    2'd0
// target log level in bits 7:0.
`define AGC_REG_REFERENCE  2'd1
// manual gain word in bits 20:0.
`define AGC_REG_MANUAL     2'd2
// integrator, read only.
`define AGC_REG_INTEGRATOR 2'd3

`endif
